// ==== Makefile ====
SRCS := $(filter-out +%,$(shell cat vlog.f))

obj_dir/Vtb_fetch: vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch -f vlog.f

.PHONY: run clean

run: obj_dir/Vtb_fetch
	./obj_dir/Vtb_fetch

clean:
	rm -rf obj_dir

// ==== btac.sv ====
`timescale 1ns/1ps

module btac import fetch_pkg::*; #(
  parameter int BTAC_ENTRIES = 4
) (
  input  logic     clock,
  input  logic     reset,
  input  addr_t    lookup_pc,
  input  resolve_t resolve,
  output pred_t    pred
);

  localparam int PTR_W = (BTAC_ENTRIES > 1) ? $clog2(BTAC_ENTRIES) : 1;

  logic [BTAC_ENTRIES-1:0] hit_vec;
  logic [BTAC_ENTRIES-1:0] match_vec;
  logic [BTAC_ENTRIES-1:0] write_vec;
  logic [BTAC_ENTRIES-1:0] clear_vec;
  addr_t                   entry_pc [BTAC_ENTRIES];
  addr_t                   entry_target [BTAC_ENTRIES];
  logic [PTR_W-1:0]        rr_ptr;
  logic                    any_match;
  logic                    allocate;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // allocation
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    for (int i = 0; i < BTAC_ENTRIES; i++) begin
      match_vec[i] = (entry_pc[i] == resolve.pc);
    end
    any_match = |match_vec;
    allocate  = resolve.valid && resolve.taken && !any_match;
    write_vec = '0;
    clear_vec = '0;
    if (resolve.valid && resolve.taken) begin
      if (any_match) begin
        write_vec = match_vec; // reuse, so no duplicates
      end else begin
        write_vec[rr_ptr] = 1'b1;
      end
    end else if (resolve.valid) begin
      clear_vec = match_vec;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      rr_ptr <= '0;
    end else if (allocate) begin
      rr_ptr <= (rr_ptr == PTR_W'(BTAC_ENTRIES - 1)) ? '0 : rr_ptr + 1'b1;
    end
  end

  for (genvar i = 0; i < BTAC_ENTRIES; i++) begin : g_entry
    btac_entry i_btac_entry (
      .clock     (clock),
      .reset     (reset),
      .write     (write_vec[i]),
      .clear     (clear_vec[i]),
      .wr_pc     (resolve.pc),
      .wr_target (resolve.target),
      .lookup_pc (lookup_pc),
      .hit       (hit_vec[i]),
      .pc        (entry_pc[i]),
      .target    (entry_target[i])
    );
  end

  // lowest index hit wins
  always_comb begin
    pred = '0;
    for (int i = BTAC_ENTRIES - 1; i >= 0; i--) begin
      if (hit_vec[i]) begin
        pred.hit    = 1'b1;
        pred.pc     = entry_pc[i];
        pred.target = entry_target[i];
      end
    end
  end

endmodule

// ==== btac_entry.sv ====
`timescale 1ns/1ps

module btac_entry import fetch_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  write,
  input  logic  clear,
  input  addr_t wr_pc,
  input  addr_t wr_target,
  input  addr_t lookup_pc,
  output logic  hit,
  output addr_t pc,
  output addr_t target
);

  logic  valid;
  addr_t pc_q;

  always_ff @(posedge clock) begin
    if (!reset) begin
      valid <= 1'b0;
    end else if (write) begin
      valid <= 1'b1;
    end else if (clear) begin
      valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (write) begin
      pc_q   <= wr_pc;
      target <= wr_target;
    end
  end

  assign hit = valid && (pc_q == lookup_pc);
  assign pc  = valid ? pc_q : NO_PC; // empty entry matches nothing on update

endmodule

// ==== fetch_assert.sv ====
`timescale 1ns/1ps

module fetch_assert import fetch_pkg::*; (
  input logic         clock,
  input logic         reset,
  input logic         halt,
  input redirect_t    redirect,
  input fetch_state_t state,
  input addr_t        pc,
  input mem_req_t     mem_req,
  input logic         mem_ready,
  input fetch_out_t   fetch
);

  int   fail_count;
  logic redirect_none;

  initial fail_count = 0;

  assign redirect_none = !(redirect.trap || redirect.mret || redirect.miss || redirect.fence);

  // no issue while halted, pc holds
  halt_blocks_issue : assert property (@(posedge clock) disable iff (!reset)
    (state == busy && halt && redirect_none) |=> ($stable(pc) && !mem_ready))
    else begin
      fail_count++;
      $error("request issued or pc moved while halt is high in busy");
    end

  // old path responses never even arrive
  no_output_in_flush : assert property (@(posedge clock) disable iff (!reset)
    (state == ctrl || state == inv) |-> (!mem_ready && !fetch.valid))
    else begin
      fail_count++;
      $error("memory response or fetch output seen in ctrl or inv");
    end

  redirect_one_hot : assert property (@(posedge clock) disable iff (!reset)
    $onehot0({redirect.trap, redirect.mret, redirect.miss, redirect.fence}))
    else begin
      fail_count++;
      $error("more than one redirect flag set");
    end

endmodule

// ==== fetch_pkg.sv ====
package fetch_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [31:0] addr_t;       // byte address
  typedef logic [63:0] instr_pair_t; // two 32-bit instructions

  localparam addr_t RESET_PC = 32'h0000_0000;
  localparam addr_t FETCH_STEP = 32'd8; // one pair per fetch

  // unaligned, so never equal to a fetch pair pc
  localparam addr_t NO_PC = 32'hffff_ffff;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fetch state machine
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [1:0] {
    idle,
    busy,
    ctrl, // drop old path after a redirect
    inv   // same, after a fence
  } fetch_state_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // interface structs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic  trap;
    logic  mret;
    logic  miss;
    logic  fence;
    addr_t target;
  } redirect_t;

  typedef struct packed {
    logic  valid;
    addr_t pc;     // pair holding the branch
    logic  taken;
    addr_t target;
  } resolve_t;

  typedef struct packed {
    logic  hit;
    addr_t pc;
    addr_t target;
  } pred_t;

  typedef struct packed {
    logic        valid;
    addr_t       pc;
    instr_pair_t rdata;
    logic        taken; // predicted taken by the btac
    addr_t       tpc;
  } fetch_out_t;

  typedef struct packed {
    logic  valid;
    logic  fence;
    logic  spec;  // first request at a redirect target
    addr_t addr;
  } mem_req_t;

endpackage

// ==== fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import fetch_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        halt,
  input  redirect_t   redirect,
  input  pred_t       pred,
  output addr_t       lookup_pc,
  output mem_req_t    mem_req,
  input  instr_pair_t mem_rdata,
  input  logic        mem_ready,
  output fetch_out_t  fetch
);

  typedef struct packed {
    fetch_state_t state;
    addr_t        pc;
    addr_t        req_pc;    // tag of the outstanding request
    logic         req_taken;
    addr_t        req_tpc;
  } fetch_reg_t;

  fetch_reg_t r;
  fetch_reg_t rin;
  fetch_reg_t v;
  logic       redirect_any;
  logic       flush;         // trap, mret or miss
  logic       issue;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // next state and next pc
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    v = r;

    flush        = redirect.trap || redirect.mret || redirect.miss;
    redirect_any = flush || redirect.fence;
    issue        = 1'b0;

    case (r.state)
      idle : begin
        v.state = busy; // one quiet cycle after reset
      end
      default : begin
        issue = !halt && !redirect_any;
      end
    endcase

    if (flush) begin
      v.pc    = redirect.target;
      v.state = ctrl;
    end else if (redirect.fence) begin
      v.pc    = redirect.target;
      v.state = inv;
    end else if (issue) begin
      v.req_pc    = r.pc;
      v.req_taken = pred.hit;
      v.req_tpc   = pred.hit ? pred.target : '0;
      if (pred.hit) begin
        v.pc = pred.target;
      end else begin
        v.pc = r.pc + FETCH_STEP;
      end
      v.state = busy; // old path is gone once the new one issues
    end

    rin = v;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      r.state <= idle;
      r.pc    <= RESET_PC;
    end else begin
      r <= rin;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory request and btac lookup
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign lookup_pc = r.pc;

  always_comb begin
    mem_req.valid = issue;
    mem_req.fence = issue && (r.state == inv);
    mem_req.spec  = issue && (r.state == ctrl || r.state == inv);
    mem_req.addr  = r.pc;
  end

  // response of the cycle before a redirect belongs to the old path
  always_comb begin
    fetch.valid = mem_ready && (r.state == busy) && !redirect_any;
    fetch.pc    = r.req_pc;
    fetch.rdata = mem_rdata;
    fetch.taken = r.req_taken;
    fetch.tpc   = r.req_tpc;
  end

endmodule

// ==== fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
  parameter int BTAC_ENTRIES = 4,
  parameter int MEM_WORDS    = 32
) (
  input  logic       clock,
  input  logic       reset,
  input  logic       halt,
  input  redirect_t  redirect,
  input  resolve_t   resolve,
  output fetch_out_t fetch
);

  addr_t       lookup_pc;
  pred_t       pred;
  mem_req_t    mem_req;
  instr_pair_t mem_rdata;
  logic        mem_ready;

  fetch_stage i_fetch_stage (
    .clock     (clock),
    .reset     (reset),
    .halt      (halt),
    .redirect  (redirect),
    .pred      (pred),
    .lookup_pc (lookup_pc),
    .mem_req   (mem_req),
    .mem_rdata (mem_rdata),
    .mem_ready (mem_ready),
    .fetch     (fetch)
  );

  btac #(
    .BTAC_ENTRIES (BTAC_ENTRIES)
  ) i_btac (
    .clock     (clock),
    .reset     (reset),
    .lookup_pc (lookup_pc),
    .resolve   (resolve), // trained straight from the back end
    .pred      (pred)
  );

  inst_mem #(
    .MEM_WORDS (MEM_WORDS)
  ) i_inst_mem (
    .clock (clock),
    .reset (reset),
    .req   (mem_req),
    .rdata (mem_rdata),
    .ready (mem_ready)
  );

endmodule

// ==== imem.hex ====
// one 64-bit instruction pair per line, word 0 first, upper half at pc+4
00208113_00100093
00408113_00300093
00608113_00500093
00808113_00700093
00a08113_00900093
00c08113_00b00093
00e08113_00d00093
01008113_00f00093
01208113_01100093
01408113_01300093
01608113_01500093
01808113_01700093
01a08113_01900093
01c08113_01b00093
01e08113_01d00093
02008113_01f00093
02208113_02100093
02408113_02300093
02608113_02500093
02808113_02700093
02a08113_02900093
02c08113_02b00093
02e08113_02d00093
03008113_02f00093
03208113_03100093
03408113_03300093
03608113_03500093
03808113_03700093
03a08113_03900093
03c08113_03b00093
03e08113_03d00093
04008113_03f00093

// ==== inst_mem.sv ====
`timescale 1ns/1ps

module inst_mem import fetch_pkg::*; #(
  parameter int MEM_WORDS = 32
) (
  input  logic        clock,
  input  logic        reset,
  input  mem_req_t    req,
  output instr_pair_t rdata,
  output logic        ready
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  instr_pair_t      rom [MEM_WORDS];
  addr_t            word_addr;
  logic [IDX_W-1:0] index;

  initial begin
    $readmemh("imem.hex", rom);
  end

  assign word_addr = req.addr >> 3;                   // one pair per word
  assign index     = IDX_W'(word_addr % MEM_WORDS);   // wraps past the end

  always_ff @(posedge clock) begin
    if (req.valid) begin
      rdata <= rom[index];
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      ready <= 1'b0;
    end else begin
      ready <= req.valid; // fixed one cycle latency
    end
  end

endmodule

// ==== tb_fetch.sv ====
`timescale 1ns/1ps

module tb_fetch import fetch_pkg::*;;

  localparam int BTAC_ENTRIES = 4;
  localparam int MEM_WORDS    = 32;
  localparam int RUN_CYCLES   = 2000;
  localparam int WAIT_LIMIT   = 20;

  logic       clock;
  logic       reset;
  logic       halt;
  redirect_t  redirect;
  resolve_t   resolve;
  fetch_out_t fetch;

  logic [15:0] lfsr;
  instr_pair_t model_mem [MEM_WORDS];
  logic        mb_valid [BTAC_ENTRIES];
  addr_t       mb_pc [BTAC_ENTRIES];
  addr_t       mb_target [BTAC_ENTRIES];
  int          mb_ptr;
  addr_t       model_pc;
  logic        model_idle;
  fetch_out_t  expect_q [$];
  int          stall;
  int          delivered;
  int          taken_count;
  int          redirect_count;
  logic        redirect_pending;
  addr_t       first_pc;

  fetch_top #(
    .BTAC_ENTRIES (BTAC_ENTRIES),
    .MEM_WORDS    (MEM_WORDS)
  ) i_fetch_top (
    .clock    (clock),
    .reset    (reset),
    .halt     (halt),
    .redirect (redirect),
    .resolve  (resolve),
    .fetch    (fetch)
  );

  bind fetch_stage fetch_assert i_fetch_assert (
    .clock     (clock),
    .reset     (reset),
    .halt      (halt),
    .redirect  (redirect),
    .state     (r.state),
    .pc        (r.pc),
    .mem_req   (mem_req),
    .mem_ready (mem_ready),
    .fetch     (fetch)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // random source and reporting
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr  = lfsr_step(lfsr);
      value = {value[30:0], lfsr[0]};
    end
    return value;
  endfunction

  function automatic addr_t random_pc();
    return addr_t'((take_bits(8) % MEM_WORDS) * 8); // aligned, inside the rom
  endfunction

  function automatic int assertion_failures();
    return i_fetch_top.i_fetch_stage.i_fetch_assert.fail_count;
  endfunction

  task automatic stop_run();
    $display(">>> FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic compare(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      stop_run();
    end
  endtask

  task automatic check_bound_assertions();
    if (assertion_failures() != 0) begin
      $display("a bound assertion on fetch_stage failed");
      stop_run();
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic int btac_lookup(input addr_t pc);
    for (int i = 0; i < BTAC_ENTRIES; i++) begin
      if (mb_valid[i] && mb_pc[i] == pc) begin
        return i; // lowest index first
      end
    end
    return -1;
  endfunction

  task automatic train_btac(input resolve_t res);
    int idx;
    idx = btac_lookup(res.pc);
    if (res.valid && res.taken) begin
      if (idx < 0) begin
        idx    = mb_ptr;
        mb_ptr = (mb_ptr + 1) % BTAC_ENTRIES; // round robin on new pcs only
      end
      mb_valid[idx]  = 1'b1;
      mb_pc[idx]     = res.pc;
      mb_target[idx] = res.target;
    end else if (res.valid && idx >= 0) begin
      mb_valid[idx] = 1'b0;
    end
  endtask

  // called mid cycle, outputs are settled
  task automatic check_and_step();
    fetch_out_t exp;
    int         idx;
    int         word;
    logic       redir;
    check_bound_assertions();
    redir = redirect.trap || redirect.mret || redirect.miss || redirect.fence;
    if (redir) begin
      expect_q.delete(); // old path is dropped
      redirect_pending = 1'b1;
    end
    if (fetch.valid) begin
      if (expect_q.size() == 0) begin
        $display("fetch output for pc %h with no request outstanding", fetch.pc);
        stop_run();
      end else begin
        exp = expect_q.pop_front();
        compare("fetch pc", 64'(exp.pc), 64'(fetch.pc));
        compare("fetch rdata", exp.rdata, fetch.rdata);
        compare("fetch taken", 64'(exp.taken), 64'(fetch.taken));
        if (exp.taken) begin
          compare("fetch tpc", 64'(exp.tpc), 64'(fetch.tpc));
          taken_count++;
        end
        if (redirect_pending) begin
          redirect_count++; // new path reached the output
          redirect_pending = 1'b0;
        end
        if (delivered == 0) first_pc = fetch.pc;
        delivered++;
        stall = 0;
      end
    end else if (expect_q.size() != 0) begin
      stall++;
      if (stall >= WAIT_LIMIT) begin
        $display("no fetch output within %0d cycles for pc %h", WAIT_LIMIT,
                 expect_q[0].pc);
        stop_run();
      end
    end else begin
      stall = 0;
    end

    // next pc by priority
    if (redir) begin
      model_pc = redirect.target;
    end else if (!model_idle && !halt) begin
      idx       = btac_lookup(model_pc);
      word      = int'((model_pc >> 3) % MEM_WORDS);
      exp       = '0;
      exp.valid = 1'b1;
      exp.pc    = model_pc;
      exp.rdata = model_mem[word];
      if (idx >= 0) begin
        exp.taken = 1'b1;
        exp.tpc   = mb_target[idx];
        model_pc  = mb_target[idx];
      end else begin
        model_pc = model_pc + 8;
      end
      expect_q.push_back(exp);
    end
    model_idle = 1'b0;
    train_btac(resolve); // lookup above saw the old state
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic drive_random();
    logic [1:0] kind;
    halt     = (take_bits(3) == 0);
    redirect = '0;
    if (take_bits(4) == 0) begin
      kind = 2'(take_bits(2));
      case (kind)
        2'd0    : redirect.trap  = 1'b1;
        2'd1    : redirect.mret  = 1'b1;
        2'd2    : redirect.miss  = 1'b1;
        default : redirect.fence = 1'b1;
      endcase
      redirect.target = random_pc();
    end
    resolve = '0;
    if (take_bits(8) < 43) begin // about 1 in 6
      resolve.valid  = 1'b1;
      resolve.pc     = random_pc();
      resolve.target = random_pc();
      resolve.taken  = take_bits(1) == 1;
    end
  endtask

  // one clock, entered just after a rising edge
  task automatic step_cycle(input logic use_random, input logic hold);
    #1;
    reset = 1'b1; // released with the first stimulus
    if (use_random) begin
      drive_random();
    end else begin
      halt     = hold;
      redirect = '0;
      resolve  = '0;
    end
    @(negedge clock);
    check_and_step();
    @(posedge clock);
  endtask

  initial begin
    int waited;
    reset    = 1'b0;
    halt     = 1'b0;
    redirect = '0;
    resolve  = '0;
    lfsr     = 16'd21;
    $readmemh("imem.hex", model_mem);
    for (int i = 0; i < BTAC_ENTRIES; i++) begin
      mb_valid[i]  = 1'b0;
      mb_pc[i]     = '0;
      mb_target[i] = '0;
    end
    mb_ptr           = 0;
    model_pc         = '0;
    model_idle       = 1'b1;
    stall            = 0;
    delivered        = 0;
    taken_count      = 0;
    redirect_count   = 0;
    redirect_pending = 1'b0;
    first_pc         = '1;

    repeat (3) @(posedge clock);

    // first pair after reset
    waited = 0;
    while (delivered == 0) begin
      if (waited >= WAIT_LIMIT) begin
        $display("no fetch output after reset within %0d cycles", WAIT_LIMIT);
        stop_run();
      end else begin
        step_cycle(1'b0, 1'b0);
        waited++;
      end
    end
    compare("first pc after reset", 64'(0), 64'(first_pc));

    for (int c = 0; c < RUN_CYCLES; c++) begin
      step_cycle(1'b1, 1'b0);
    end

    // hold halt and let the last request drain
    waited = 0;
    while (expect_q.size() != 0) begin
      if (waited >= WAIT_LIMIT) begin
        $display("outstanding request not delivered within %0d cycles", WAIT_LIMIT);
        stop_run();
      end else begin
        step_cycle(1'b0, 1'b1);
        waited++;
      end
    end

    compare("taken pairs seen", 64'(1), 64'(taken_count > 0));
    compare("redirect targets delivered", 64'(1), 64'(redirect_count > 0));
    if (assertion_failures() != 0) begin
      $display("a bound assertion on fetch_stage failed");
      stop_run();
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

// ==== vlog.f ====
fetch_pkg.sv
btac_entry.sv
btac.sv
inst_mem.sv
fetch_stage.sv
fetch_top.sv
fetch_assert.sv
tb_fetch.sv
